/* common/backend_pkg.sv */
`default_nettype none

package backend_pkg;

  localparam int ARCH_REGS   = 16;
  localparam int AREG_W      = 4;
  localparam int PHYS_REGS   = 32;
  localparam int PREG_W      = 5;
  localparam int WORD_W      = 32;
  localparam int PC_W        = 32;
  localparam int ROB_ENTRIES = 8;
  localparam int ROB_W       = 3;
  localparam int OFFSET_W    = 19;
  localparam int UOP_W       = 27;
  localparam int OPC_W       = 3;
  localparam int COND_W      = 2;
  localparam int IMM_W       = 12;

  // free list only ever holds the registers beyond the architectural set
  localparam int FL_ENTRIES  = PHYS_REGS - ARCH_REGS;
  localparam int FL_W        = 4;

  localparam logic [OPC_W-1:0] OP_ADD  = 3'd0;
  localparam logic [OPC_W-1:0] OP_SUB  = 3'd1;
  localparam logic [OPC_W-1:0] OP_AND  = 3'd2;
  localparam logic [OPC_W-1:0] OP_XOR  = 3'd3;
  localparam logic [OPC_W-1:0] OP_MOVI = 3'd4;  // sign-extended imm

  localparam logic [COND_W-1:0] COND_EQZ    = 2'd0;
  localparam logic [COND_W-1:0] COND_NEZ    = 2'd1;
  localparam logic [COND_W-1:0] COND_LTZ    = 2'd2;
  localparam logic [COND_W-1:0] COND_ALWAYS = 2'd3;

  // is_branch travels beside the word and picks the member
  typedef union packed {
    struct packed {
      logic [OPC_W-1:0]    opcode;
      logic [AREG_W-1:0]   rd;
      logic [AREG_W-1:0]   rs1;
      logic [AREG_W-1:0]   rs2;
      logic [IMM_W-1:0]    imm;
    } alu;
    struct packed {
      logic [COND_W-1:0]   cond;
      logic                predict_taken;
      logic [AREG_W-1:0]   rs1;       // tested register
      logic [OFFSET_W-1:0] offset;
      logic                pad;
    } br;
  } uop_u;

endpackage

`default_nettype wire

/* common/backend_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

// rename -> rob, one instruction per cycle
interface dispatch_if import backend_pkg::*; ();
  logic              valid;
  logic              ready;
  logic              is_branch;
  uop_u              uop;
  logic [PC_W-1:0]   pc;
  logic [AREG_W-1:0] rd;
  logic [PREG_W-1:0] new_preg;
  logic [PREG_W-1:0] old_preg;   // previous mapping of rd
  logic [PREG_W-1:0] src1_preg;
  logic [PREG_W-1:0] src2_preg;

  modport driver (output valid, is_branch, uop, pc, rd, new_preg, old_preg,
                  output src1_preg, src2_preg, input ready);
  modport receiver (input valid, is_branch, uop, pc, rd, new_preg, old_preg,
                    input src1_preg, src2_preg, output ready);
endinterface

interface issue_if import backend_pkg::*; ();
  logic              valid;
  logic              ready;
  logic [ROB_W-1:0]  rob_idx;
  uop_u              uop;
  logic [PREG_W-1:0] dest_preg;
  logic [WORD_W-1:0] op_a;
  logic [WORD_W-1:0] op_b;

  modport driver (output valid, rob_idx, uop, dest_preg, op_a, op_b, input ready);
  modport receiver (input valid, rob_idx, uop, dest_preg, op_a, op_b, output ready);
endinterface

interface wb_if import backend_pkg::*; ();
  logic              valid;
  logic [ROB_W-1:0]  rob_idx;
  logic [PREG_W-1:0] dest_preg;
  logic [WORD_W-1:0] value;
  logic              has_dest;
  logic              taken;
  logic              mispredict;

  modport driver (output valid, rob_idx, dest_preg, value, has_dest, taken, mispredict);
  modport receiver (input valid, rob_idx, dest_preg, value, has_dest, taken, mispredict);
endinterface

// no ready, committed map and free list always take it
interface retire_if import backend_pkg::*; ();
  logic              valid;
  logic              has_dest;
  logic [AREG_W-1:0] rd;
  logic [PREG_W-1:0] new_preg;
  logic [PREG_W-1:0] old_preg;

  modport driver (output valid, has_dest, rd, new_preg, old_preg);
  modport receiver (input valid, has_dest, rd, new_preg, old_preg);
endinterface

`default_nettype wire

/* rename/rename_map.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_map import backend_pkg::*; (
  input  logic              clk_in,
  input  logic              rst,
  input  logic              instr_valid,
  input  logic              instr_is_branch,
  input  logic [PC_W-1:0]   instr_pc,
  input  uop_u              instr_uop,
  input  logic              fl_empty,
  output logic              fl_pop,
  input  logic [PREG_W-1:0] fl_preg,
  output logic              alloc_valid,
  output logic [PREG_W-1:0] alloc_preg,
  dispatch_if.driver        dispatch,
  retire_if.receiver        retire
);

  logic [PREG_W-1:0] spec_map [ARCH_REGS];
  logic [PREG_W-1:0] comm_map [ARCH_REGS];  // architectural state, for recovery later
  logic [AREG_W-1:0] src1_areg;
  logic              accept;

  // both forms keep rs1, but at different bit positions
  assign src1_areg = instr_is_branch ? instr_uop.br.rs1 : instr_uop.alu.rs1;

  assign dispatch.valid     = instr_valid && !fl_empty;
  assign dispatch.is_branch = instr_is_branch;
  assign dispatch.uop       = instr_uop;
  assign dispatch.pc        = instr_pc;
  assign dispatch.rd        = instr_uop.alu.rd;
  assign dispatch.new_preg  = fl_preg;
  assign dispatch.old_preg  = spec_map[instr_uop.alu.rd];
  assign dispatch.src1_preg = spec_map[src1_areg];
  // a branch reads one register, so both busy checks look at it
  assign dispatch.src2_preg = instr_is_branch ? spec_map[src1_areg]
                                              : spec_map[instr_uop.alu.rs2];

  assign accept      = dispatch.valid && dispatch.ready;
  assign fl_pop      = accept && !instr_is_branch;  // branches write nothing
  assign alloc_valid = fl_pop;
  assign alloc_preg  = fl_preg;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        spec_map[i] <= PREG_W'(i);  // identity mapping
        comm_map[i] <= PREG_W'(i);
      end
    end else begin
      if (fl_pop) begin
        spec_map[instr_uop.alu.rd] <= fl_preg;
      end
      if (retire.valid && retire.has_dest) begin
        comm_map[retire.rd] <= retire.new_preg;
      end
    end
  end

endmodule

`default_nettype wire

/* rename/free_list.sv */
`timescale 1ns/100ps
`default_nettype none

module free_list import backend_pkg::*; (
  input  logic              clk_in,
  input  logic              rst,
  input  logic              pop,
  output logic [PREG_W-1:0] head_preg,
  output logic              empty,
  retire_if.receiver        retire
);

  logic [PREG_W-1:0] queue [FL_ENTRIES];
  logic [FL_W-1:0]   head;
  logic [FL_W-1:0]   tail;
  logic [FL_W:0]     count;
  logic              push;

  assign push      = retire.valid && retire.has_dest;  // old preg comes back
  assign head_preg = queue[head];
  assign empty     = (count == '0);

  always_ff @(posedge clk_in) begin
    if (rst) begin
      // starts full with the registers above the architectural ones
      for (int i = 0; i < FL_ENTRIES; i++) begin
        queue[i] <= PREG_W'(ARCH_REGS + i);
      end
      head  <= '0;
      tail  <= '0;  // full queue, tail has wrapped onto head
      count <= (FL_W+1)'(FL_ENTRIES);
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (push) begin
        queue[tail] <= retire.old_preg;
        tail        <= tail + 1'b1;
      end
      count <= count + (FL_W+1)'(push) - (FL_W+1)'(pop);
    end
  end

endmodule

`default_nettype wire

/* rob/reorder_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer import backend_pkg::*; (
  input  logic                clk_in,
  input  logic                rst,
  dispatch_if.receiver        dispatch,
  issue_if.driver             alu_issue,
  issue_if.driver             br_issue,
  wb_if.receiver              alu_wb,
  wb_if.receiver              br_wb,
  output logic [PREG_W-1:0]   rd_preg_a,
  output logic [PREG_W-1:0]   rd_preg_b,
  output logic [PREG_W-1:0]   rd_preg_c,
  output logic [PREG_W-1:0]   rd_preg_d,
  input  logic [WORD_W-1:0]   rd_data_a,
  input  logic [WORD_W-1:0]   rd_data_b,
  input  logic [WORD_W-1:0]   rd_data_c,
  input  logic [WORD_W-1:0]   rd_data_d,
  input  logic [PHYS_REGS-1:0] busy,
  retire_if.driver            retire,
  output logic [WORD_W-1:0]   retire_value,
  output logic                bcond_resolved_out,
  output logic                taken_out,
  output logic                pc_incorrect_out,
  output logic [PC_W-1:0]     pc_out,
  output logic [OFFSET_W-1:0] correction_offset_out
);

  logic              e_valid     [ROB_ENTRIES];
  logic              e_issued    [ROB_ENTRIES];
  logic              e_done      [ROB_ENTRIES];
  logic              e_is_branch [ROB_ENTRIES];
  uop_u              e_uop       [ROB_ENTRIES];
  logic [PC_W-1:0]   e_pc        [ROB_ENTRIES];
  logic [AREG_W-1:0] e_rd        [ROB_ENTRIES];
  logic [PREG_W-1:0] e_new_preg  [ROB_ENTRIES];
  logic [PREG_W-1:0] e_old_preg  [ROB_ENTRIES];
  logic [PREG_W-1:0] e_src1      [ROB_ENTRIES];
  logic [PREG_W-1:0] e_src2      [ROB_ENTRIES];
  logic [WORD_W-1:0] e_result    [ROB_ENTRIES];
  logic              e_taken     [ROB_ENTRIES];
  logic              e_mispred   [ROB_ENTRIES];

  logic [ROB_W-1:0]  head;
  logic [ROB_W-1:0]  tail;
  logic [ROB_W:0]    count;
  logic              push;
  logic              retire_now;
  logic              alu_found;
  logic              br_found;
  logic [ROB_W-1:0]  alu_sel;
  logic [ROB_W-1:0]  br_sel;

  assign dispatch.ready = (count != ROB_ENTRIES);
  assign push           = dispatch.valid && dispatch.ready;
  assign retire_now     = e_valid[head] && e_done[head];

  // walk from head so the first hit per class is the oldest one
  always_comb begin
    logic [ROB_W-1:0] idx;
    alu_found = 1'b0;
    br_found  = 1'b0;
    alu_sel   = head;
    br_sel    = head;
    for (int i = 0; i < ROB_ENTRIES; i++) begin
      idx = head + ROB_W'(i);
      if (e_valid[idx] && !e_issued[idx] && !busy[e_src1[idx]] && !busy[e_src2[idx]]) begin
        if (e_is_branch[idx] && !br_found) begin
          br_found = 1'b1;
          br_sel   = idx;
        end else if (!e_is_branch[idx] && !alu_found) begin
          alu_found = 1'b1;
          alu_sel   = idx;
        end
      end
    end
  end

  assign rd_preg_a = e_src1[alu_sel];
  assign rd_preg_b = e_src2[alu_sel];
  assign rd_preg_c = e_src1[br_sel];
  assign rd_preg_d = e_src2[br_sel];

  assign alu_issue.valid     = alu_found;
  assign alu_issue.rob_idx   = alu_sel;
  assign alu_issue.uop       = e_uop[alu_sel];
  assign alu_issue.dest_preg = e_new_preg[alu_sel];
  assign alu_issue.op_a      = rd_data_a;
  assign alu_issue.op_b      = rd_data_b;

  assign br_issue.valid      = br_found;
  assign br_issue.rob_idx    = br_sel;
  assign br_issue.uop        = e_uop[br_sel];
  assign br_issue.dest_preg  = e_new_preg[br_sel];
  assign br_issue.op_a       = rd_data_c;
  assign br_issue.op_b       = rd_data_d;

  always_ff @(posedge clk_in) begin
    if (rst) begin
      head               <= '0;
      tail               <= '0;
      count              <= '0;
      retire.valid       <= 1'b0;
      bcond_resolved_out <= 1'b0;
      for (int i = 0; i < ROB_ENTRIES; i++) begin
        e_valid[i]  <= 1'b0;
        e_issued[i] <= 1'b0;
        e_done[i]   <= 1'b0;
      end
    end else begin
      if (push) begin
        e_valid[tail]  <= 1'b1;
        e_issued[tail] <= 1'b0;
        e_done[tail]   <= 1'b0;
        tail           <= tail + 1'b1;
      end
      if (alu_issue.valid && alu_issue.ready) e_issued[alu_sel] <= 1'b1;
      if (br_issue.valid && br_issue.ready)   e_issued[br_sel]  <= 1'b1;
      if (alu_wb.valid) e_done[alu_wb.rob_idx] <= 1'b1;
      if (br_wb.valid)  e_done[br_wb.rob_idx]  <= 1'b1;
      if (retire_now) begin
        e_valid[head] <= 1'b0;
        head          <= head + 1'b1;
      end
      retire.valid       <= retire_now;
      bcond_resolved_out <= retire_now && e_is_branch[head];
      count <= count + (ROB_W+1)'(push) - (ROB_W+1)'(retire_now);
    end
  end

  // entry payload and retire outputs
  always_ff @(posedge clk_in) begin
    if (push) begin
      e_is_branch[tail] <= dispatch.is_branch;
      e_uop[tail]       <= dispatch.uop;
      e_pc[tail]        <= dispatch.pc;
      e_rd[tail]        <= dispatch.rd;
      e_new_preg[tail]  <= dispatch.new_preg;
      e_old_preg[tail]  <= dispatch.old_preg;
      e_src1[tail]      <= dispatch.src1_preg;
      e_src2[tail]      <= dispatch.src2_preg;
    end
    if (alu_wb.valid) e_result[alu_wb.rob_idx] <= alu_wb.value;
    if (br_wb.valid) begin
      e_result[br_wb.rob_idx]  <= br_wb.value;
      e_taken[br_wb.rob_idx]   <= br_wb.taken;
      e_mispred[br_wb.rob_idx] <= br_wb.mispredict;
    end
    if (retire_now) begin
      retire.has_dest       <= !e_is_branch[head];
      retire.rd             <= e_rd[head];
      retire.new_preg       <= e_new_preg[head];
      retire.old_preg       <= e_old_preg[head];
      retire_value          <= e_result[head];
      taken_out             <= e_taken[head];
      pc_incorrect_out      <= e_mispred[head];
      pc_out                <= e_pc[head];
      correction_offset_out <= e_uop[head].br.offset;  // offset echoed back
    end
  end

endmodule

`default_nettype wire

/* src/phys_reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module phys_reg_file import backend_pkg::*; (
  input  logic                 clk_in,
  input  logic                 rst,
  input  logic [PREG_W-1:0]    rd_preg_a,
  input  logic [PREG_W-1:0]    rd_preg_b,
  input  logic [PREG_W-1:0]    rd_preg_c,
  input  logic [PREG_W-1:0]    rd_preg_d,
  output logic [WORD_W-1:0]    rd_data_a,
  output logic [WORD_W-1:0]    rd_data_b,
  output logic [WORD_W-1:0]    rd_data_c,
  output logic [WORD_W-1:0]    rd_data_d,
  wb_if.receiver               alu_wb,
  wb_if.receiver               br_wb,
  input  logic                 alloc_valid,
  input  logic [PREG_W-1:0]    alloc_preg,
  output logic [PHYS_REGS-1:0] busy          // scoreboard
);

  logic [WORD_W-1:0] regs [PHYS_REGS];

  assign rd_data_a = regs[rd_preg_a];  // alu pair
  assign rd_data_b = regs[rd_preg_b];
  assign rd_data_c = regs[rd_preg_c];  // branch pair
  assign rd_data_d = regs[rd_preg_d];

  always_ff @(posedge clk_in) begin
    if (rst) begin
      for (int i = 0; i < PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
      busy <= '0;
    end else begin
      if (alu_wb.valid && alu_wb.has_dest) begin
        regs[alu_wb.dest_preg] <= alu_wb.value;
        busy[alu_wb.dest_preg] <= 1'b0;
      end
      if (br_wb.valid && br_wb.has_dest) begin
        regs[br_wb.dest_preg] <= br_wb.value;
        busy[br_wb.dest_preg] <= 1'b0;
      end
      // a freshly allocated preg is never one in flight
      if (alloc_valid) busy[alloc_preg] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/alu_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_unit import backend_pkg::*; (
  input  logic     clk_in,
  input  logic     rst,
  issue_if.receiver issue,
  wb_if.driver     wb
);

  logic [WORD_W-1:0] result;

  always_comb begin
    case (issue.uop.alu.opcode)
      OP_ADD:  result = issue.op_a + issue.op_b;  // wraps at word width
      OP_SUB:  result = issue.op_a - issue.op_b;
      OP_AND:  result = issue.op_a & issue.op_b;
      OP_XOR:  result = issue.op_a ^ issue.op_b;
      OP_MOVI: result = {{(WORD_W-IMM_W){issue.uop.alu.imm[IMM_W-1]}}, issue.uop.alu.imm};
      default: result = '0;
    endcase
  end

  assign issue.ready   = 1'b1;  // single cycle, never stalls
  assign wb.has_dest   = 1'b1;
  assign wb.taken      = 1'b0;
  assign wb.mispredict = 1'b0;

  always_ff @(posedge clk_in) begin
    if (rst) wb.valid <= 1'b0;
    else     wb.valid <= issue.valid && issue.ready;
  end

  always_ff @(posedge clk_in) begin
    if (issue.valid) begin
      wb.rob_idx   <= issue.rob_idx;
      wb.dest_preg <= issue.dest_preg;
      wb.value     <= result;
    end
  end

endmodule

`default_nettype wire

/* src/branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_unit import backend_pkg::*; (
  input  logic     clk_in,
  input  logic     rst,
  issue_if.receiver issue,
  wb_if.driver     wb
);

  logic taken;

  // condition is tested on rs1 only
  always_comb begin
    taken = 1'b0;
    case (issue.uop.br.cond)
      COND_EQZ:    taken = (issue.op_a == '0);
      COND_NEZ:    taken = (issue.op_a != '0);
      COND_LTZ:    taken = issue.op_a[WORD_W-1];  // sign bit
      COND_ALWAYS: taken = 1'b1;
      default:     taken = 1'b0;
    endcase
  end

  assign issue.ready  = 1'b1;
  assign wb.has_dest  = 1'b0;  // branches write no register
  assign wb.dest_preg = '0;
  assign wb.value     = '0;

  always_ff @(posedge clk_in) begin
    if (rst) wb.valid <= 1'b0;
    else     wb.valid <= issue.valid && issue.ready;
  end

  always_ff @(posedge clk_in) begin
    if (issue.valid) begin
      wb.rob_idx    <= issue.rob_idx;
      wb.taken      <= taken;
      wb.mispredict <= issue.uop.br.predict_taken != taken;
    end
  end

endmodule

`default_nettype wire

/* src/backend.sv */
`timescale 1ns/100ps
`default_nettype none

module backend import backend_pkg::*; (
  input  logic                clk_in,
  input  logic                rst,
  input  logic                instr_valid,
  input  logic                instr_is_branch,
  input  logic [PC_W-1:0]     instr_pc,
  input  logic [UOP_W-1:0]    instr_uop,
  output logic                ready_out,
  output logic                retire_valid,
  output logic [AREG_W-1:0]   retire_rd,
  output logic [WORD_W-1:0]   retire_value,
  // to the branch predictor, valid with bcond_resolved_out
  output logic                bcond_resolved_out,
  output logic                taken_out,
  output logic                pc_incorrect_out,
  output logic [PC_W-1:0]     pc_out,
  output logic [OFFSET_W-1:0] correction_offset_out
);

  dispatch_if dispatch ();
  issue_if    alu_issue ();
  issue_if    br_issue ();
  wb_if       alu_wb ();
  wb_if       br_wb ();
  retire_if   retire ();

  logic                 fl_empty;
  logic                 fl_pop;
  logic [PREG_W-1:0]    fl_preg;
  logic                 alloc_valid;
  logic [PREG_W-1:0]    alloc_preg;
  logic [PREG_W-1:0]    rd_preg_a, rd_preg_b, rd_preg_c, rd_preg_d;
  logic [WORD_W-1:0]    rd_data_a, rd_data_b, rd_data_c, rd_data_d;
  logic [PHYS_REGS-1:0] busy;

  // same condition for every instruction, branch or not
  assign ready_out    = dispatch.ready && !fl_empty;
  assign retire_valid = retire.valid;
  assign retire_rd    = retire.rd;

  rename_map rename_map_inst (
    .clk_in(clk_in), .rst(rst),
    .instr_valid(instr_valid), .instr_is_branch(instr_is_branch),
    .instr_pc(instr_pc), .instr_uop(instr_uop),
    .fl_empty(fl_empty), .fl_pop(fl_pop), .fl_preg(fl_preg),
    .alloc_valid(alloc_valid), .alloc_preg(alloc_preg),
    .dispatch(dispatch), .retire(retire)
  );

  free_list free_list_inst (
    .clk_in(clk_in), .rst(rst), .pop(fl_pop),
    .head_preg(fl_preg), .empty(fl_empty), .retire(retire)
  );

  reorder_buffer rob_inst (
    .clk_in(clk_in), .rst(rst), .dispatch(dispatch),
    .alu_issue(alu_issue), .br_issue(br_issue), .alu_wb(alu_wb), .br_wb(br_wb),
    .rd_preg_a(rd_preg_a), .rd_preg_b(rd_preg_b),
    .rd_preg_c(rd_preg_c), .rd_preg_d(rd_preg_d),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .rd_data_c(rd_data_c), .rd_data_d(rd_data_d),
    .busy(busy), .retire(retire), .retire_value(retire_value),
    .bcond_resolved_out(bcond_resolved_out), .taken_out(taken_out),
    .pc_incorrect_out(pc_incorrect_out), .pc_out(pc_out),
    .correction_offset_out(correction_offset_out)
  );

  phys_reg_file prf_inst (
    .clk_in(clk_in), .rst(rst),
    .rd_preg_a(rd_preg_a), .rd_preg_b(rd_preg_b),
    .rd_preg_c(rd_preg_c), .rd_preg_d(rd_preg_d),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .rd_data_c(rd_data_c), .rd_data_d(rd_data_d),
    .alu_wb(alu_wb), .br_wb(br_wb),
    .alloc_valid(alloc_valid), .alloc_preg(alloc_preg), .busy(busy)
  );

  alu_unit alu_inst (.clk_in(clk_in), .rst(rst), .issue(alu_issue), .wb(alu_wb));

  branch_unit bru_inst (.clk_in(clk_in), .rst(rst), .issue(br_issue), .wb(br_wb));

endmodule

`default_nettype wire

/* tests/clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
  output logic clk
);

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

endmodule

`default_nettype wire

/* tests/backend_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module backend_tb import backend_pkg::*; ();

  localparam int          NUM_INSTR      = 400;
  localparam int          RST_CYCLES     = 8;
  localparam int          TIMEOUT_CYCLES = NUM_INSTR * 30;
  localparam logic [31:0] SEED           = 32'hf21e78b5;

  logic                clk_in;
  logic                rst;
  logic                instr_valid;
  logic                instr_is_branch;
  logic [PC_W-1:0]     instr_pc;
  logic [UOP_W-1:0]    instr_uop;
  logic                ready_out;
  logic                retire_valid;
  logic [AREG_W-1:0]   retire_rd;
  logic [WORD_W-1:0]   retire_value;
  logic                bcond_resolved_out;
  logic                taken_out;
  logic                pc_incorrect_out;
  logic [PC_W-1:0]     pc_out;
  logic [OFFSET_W-1:0] correction_offset_out;

  // in-order architectural model and its expected retire stream
  logic [WORD_W-1:0]   arch_regs [ARCH_REGS];
  logic                q_branch  [$];
  logic [AREG_W-1:0]   q_rd      [$];
  logic [WORD_W-1:0]   q_value   [$];
  logic                q_taken   [$];
  logic                q_mispred [$];
  logic [PC_W-1:0]     q_pc      [$];
  logic [OFFSET_W-1:0] q_offset  [$];

  int                  retired_count;
  int                  stall_cycles;
  int                  burst_left;
  logic [AREG_W-1:0]   last_rd;

  clk_gen clk_gen_inst (.clk(clk_in));

  backend backend_inst (
    .clk_in(clk_in), .rst(rst),
    .instr_valid(instr_valid), .instr_is_branch(instr_is_branch),
    .instr_pc(instr_pc), .instr_uop(instr_uop),
    .ready_out(ready_out), .retire_valid(retire_valid),
    .retire_rd(retire_rd), .retire_value(retire_value),
    .bcond_resolved_out(bcond_resolved_out), .taken_out(taken_out),
    .pc_incorrect_out(pc_incorrect_out), .pc_out(pc_out),
    .correction_offset_out(correction_offset_out)
  );

  function automatic logic [WORD_W-1:0] alu_model(input logic [OPC_W-1:0] opc,
      input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b, input logic [IMM_W-1:0] imm);
    case (opc)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return WORD_W'($signed(imm));  // movi
    endcase
  endfunction

  function automatic logic cond_model(input logic [COND_W-1:0] cond,
      input logic [WORD_W-1:0] v);
    case (cond)
      COND_EQZ: return v == 0;
      COND_NEZ: return v != 0;
      COND_LTZ: return $signed(v) < 0;
      default:  return 1'b1;
    endcase
  endfunction

  task automatic end_with_failure();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic flag_mismatch(input string msg);
    $display("Error at %0t: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic report_problem(input string msg);
    $display("%s", msg);
    end_with_failure();
  endtask

  task automatic check_retire(input logic [AREG_W-1:0] got_rd, input logic [AREG_W-1:0] exp_rd,
      input logic [WORD_W-1:0] got_value, input logic [WORD_W-1:0] exp_value);
    if (got_rd !== exp_rd)
      flag_mismatch($sformatf("retire rd is r%0d, expected r%0d", got_rd, exp_rd));
    if (got_value !== exp_value)
      flag_mismatch($sformatf("r%0d retired %h, expected %h", exp_rd, got_value, exp_value));
  endtask

  task automatic check_branch(input logic got_taken, input logic exp_taken,
      input logic got_mispred, input logic exp_mispred,
      input logic [PC_W-1:0] got_pc, input logic [PC_W-1:0] exp_pc,
      input logic [OFFSET_W-1:0] got_offset, input logic [OFFSET_W-1:0] exp_offset);
    if (got_pc !== exp_pc)
      flag_mismatch($sformatf("branch pc %h, expected %h", got_pc, exp_pc));
    if (got_taken !== exp_taken)
      flag_mismatch($sformatf("branch at %h taken %b, expected %b",
                              exp_pc, got_taken, exp_taken));
    if (got_mispred !== exp_mispred)
      flag_mismatch($sformatf("branch at %h pc_incorrect %b, expected %b",
                              exp_pc, got_mispred, exp_mispred));
    if (got_offset !== exp_offset)
      flag_mismatch($sformatf("branch at %h offset %h, expected %h",
                              exp_pc, got_offset, exp_offset));
  endtask

  // dependent bursts chain rs1 on the previous rd so the rob fills up
  task automatic make_instr(output logic br, output uop_u u, output logic [PC_W-1:0] pc);
    u  = '0;
    pc = '0;
    if (burst_left == 0 && ($urandom % 12) == 0) burst_left = 10 + $urandom % 6;
    if (burst_left > 0) begin
      burst_left--;
      br           = 1'b0;
      u.alu.opcode = OPC_W'($urandom % 4);
      u.alu.rs1    = last_rd;
      u.alu.rs2    = AREG_W'($urandom);
    end else begin
      br = ($urandom % 10) < 3;
      if (br) begin
        u.br.cond          = COND_W'($urandom);
        u.br.predict_taken = $urandom % 2;
        u.br.rs1           = AREG_W'($urandom);
        u.br.offset        = OFFSET_W'($urandom);
        pc                 = $urandom;
      end else begin
        u.alu.opcode = OPC_W'($urandom % 5);  // add..movi
        u.alu.rs1    = AREG_W'($urandom);
        u.alu.rs2    = AREG_W'($urandom);
      end
    end
    if (!br) begin
      u.alu.rd  = AREG_W'($urandom);
      u.alu.imm = IMM_W'($urandom);
      last_rd   = u.alu.rd;
    end
  endtask

  task automatic accept_model(input logic br, input uop_u u, input logic [PC_W-1:0] pc);
    logic [WORD_W-1:0] res;
    logic              tk;
    q_branch.push_back(br);
    if (br) begin
      tk = cond_model(u.br.cond, arch_regs[u.br.rs1]);
      q_rd.push_back('0);
      q_value.push_back('0);
      q_taken.push_back(tk);
      q_mispred.push_back(u.br.predict_taken != tk);
      q_pc.push_back(pc);
      q_offset.push_back(u.br.offset);
    end else begin
      res = alu_model(u.alu.opcode, arch_regs[u.alu.rs1], arch_regs[u.alu.rs2], u.alu.imm);
      arch_regs[u.alu.rd] = res;
      q_rd.push_back(u.alu.rd);
      q_value.push_back(res);
      q_taken.push_back(1'b0);
      q_mispred.push_back(1'b0);
      q_pc.push_back('0);
      q_offset.push_back('0);
    end
  endtask

  initial begin : stimulus
    logic            br;
    uop_u            u;
    logic [PC_W-1:0] pc;
    int              gap;
    void'($urandom(SEED));
    rst             = 1'b1;
    instr_valid     = 1'b0;
    instr_is_branch = 1'b0;
    instr_pc        = '0;
    instr_uop       = '0;
    retired_count   = 0;
    stall_cycles    = 0;
    burst_left      = 0;
    last_rd         = '0;
    for (int i = 0; i < ARCH_REGS; i++) arch_regs[i] = '0;
    repeat (RST_CYCLES) @(posedge clk_in);
    rst <= 1'b0;
    repeat (3) begin  // quiet window before the first instruction
      @(negedge clk_in);
      if (ready_out !== 1'b1) report_problem("ready_out is not high after reset");
      if (retire_valid !== 1'b0 || bcond_resolved_out !== 1'b0)
        report_problem("retire outputs active before any instruction was accepted");
    end
    for (int n = 0; n < NUM_INSTR; n++) begin
      if (burst_left == 0 && ($urandom % 4) == 0) begin
        gap = 1 + $urandom % 3;
        @(posedge clk_in);
        instr_valid <= 1'b0;
        repeat (gap - 1) @(posedge clk_in);
      end
      make_instr(br, u, pc);
      @(posedge clk_in);
      instr_valid     <= 1'b1;
      instr_is_branch <= br;
      instr_pc        <= pc;
      instr_uop       <= u;
      @(negedge clk_in);
      while (ready_out !== 1'b1) begin  // held until the dut takes it
        stall_cycles++;
        @(negedge clk_in);
      end
      accept_model(br, u, pc);  // taken on the coming edge
    end
    @(posedge clk_in);
    instr_valid <= 1'b0;
    while (retired_count < NUM_INSTR) @(negedge clk_in);
    repeat (10) @(negedge clk_in);  // a duplicate retire would show up here
    if (stall_cycles > 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      report_problem("ready_out never dropped, so back-pressure was never exercised");
    end
  end

  always @(negedge clk_in) begin : retire_monitor
    logic exp_br;
    if (!rst) begin
      if (bcond_resolved_out === 1'b1 && retire_valid !== 1'b1)
        report_problem("bcond_resolved_out went high without retire_valid");
      if (retire_valid === 1'b1) begin
        if (q_branch.size() == 0)
          report_problem("retire_valid seen with no accepted instruction outstanding");
        exp_br = q_branch.pop_front();
        if (bcond_resolved_out !== exp_br)
          flag_mismatch($sformatf("bcond_resolved_out %b, expected %b",
                                  bcond_resolved_out, exp_br));
        if (exp_br)
          check_branch(taken_out, q_taken.pop_front(), pc_incorrect_out, q_mispred.pop_front(),
                       pc_out, q_pc.pop_front(), correction_offset_out, q_offset.pop_front());
        else
          check_retire(retire_rd, q_rd.pop_front(), retire_value, q_value.pop_front());
        if (exp_br) begin
          void'(q_rd.pop_front());
          void'(q_value.pop_front());
        end else begin
          void'(q_taken.pop_front());
          void'(q_mispred.pop_front());
          void'(q_pc.pop_front());
          void'(q_offset.pop_front());
        end
        retired_count++;
      end
    end
  end

  initial begin : watchdog
    repeat (RST_CYCLES + TIMEOUT_CYCLES) @(posedge clk_in);
    report_problem($sformatf("timeout after %0d cycles with %0d of %0d instructions retired",
                             TIMEOUT_CYCLES, retired_count, NUM_INSTR));
  end

endmodule

`default_nettype wire

/* sim.f */
common/backend_pkg.sv
common/backend_ifs.sv
rename/rename_map.sv
rename/free_list.sv
rob/reorder_buffer.sv
src/phys_reg_file.sv
src/alu_unit.sv
src/branch_unit.sv
src/backend.sv
tests/clk_gen.sv
tests/backend_tb.sv
